// File: source/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

	// one byte on the bus: address+rw, register, data or received byte
	typedef logic [7:0] byte_t;
	// 7-bit device address, rw bit appended by the sequencer
	typedef logic [6:0] dev_addr_t;
	// clock-rate code, bit period is 2^(code+1) system clocks
	typedef logic [2:0] rate_t;
	// index into the read buffer, also used as a byte count
	typedef logic [3:0] rd_idx_t;

	// commands from sequencer to byte engine
	typedef enum logic [1:0] {
		CMD_START = 2'd0,
		CMD_STOP  = 2'd1,
		CMD_WRITE = 2'd2,
		CMD_READ  = 2'd3
	} bus_cmd_e;

	// job phases
	// first half is the pointer write, second half only for reads
	typedef enum logic [3:0] {
		ST_IDLE,
		ST_START1,
		ST_ADDR_W,
		ST_REG,
		ST_DATA,
		ST_STOP1,
		ST_START2,
		ST_ADDR_R,
		ST_READ,
		ST_STOP2
	} seq_state_e;

	// bytes per burst read
	localparam int BURST_LEN = 11;

	// legal rate codes and the fallback for anything else
	localparam rate_t RATE_MIN = 3'd4;
	localparam rate_t RATE_MAX = 3'd7;
	localparam rate_t RATE_DEFAULT = 3'd6;

	// tick phases per bus bit
	localparam int QUARTERS_PER_BIT = 4;

endpackage

`default_nettype wire

// File: source/i2c_bit_timer.sv
`default_nettype none

module i2c_bit_timer import i2c_pkg::*; (
	input wire logic i_clk,
	input wire logic i_rst_n,
	input wire logic i_en,
	input wire rate_t i_rate,
	output logic o_tick
);

	// rate code after the legality check
	rate_t rate_eff;
	// clocks per quarter bit, up to 64
	logic [6:0] interval;
	logic [6:0] cnt;

	// out-of-range codes run at the default speed
	assign rate_eff = (i_rate >= RATE_MIN && i_rate <= RATE_MAX) ? i_rate : RATE_DEFAULT;
	// quarter bit = bit period / 4 = 2^(code-1)
	assign interval = 7'd1 << (rate_eff - rate_t'(1));

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt <= '0;
			o_tick <= 1'b0;
		end else if (!i_en) begin
			// idle bus, restart the count for the next job
			cnt <= '0;
			o_tick <= 1'b0;
		end else if (cnt == interval - 7'd1) begin
			cnt <= '0;
			o_tick <= 1'b1;
		end else begin
			cnt <= cnt + 7'd1;
			o_tick <= 1'b0;
		end
	end

	// shortest interval is 8 clocks, so ticks never touch
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_tick |=> !o_tick);

endmodule

`default_nettype wire

// File: source/i2c_txn_sequencer.sv
`default_nettype none

module i2c_txn_sequencer import i2c_pkg::*; (
	input wire logic i_clk,
	input wire logic i_rst_n,
	input wire logic i_start,
	input wire logic i_rw,
	input wire logic i_burst,
	input wire dev_addr_t i_dev_addr,
	input wire byte_t i_reg_addr,
	input wire byte_t i_w_data,
	input wire rate_t i_clk_rate,
	input wire logic i_cmd_done,
	input wire logic i_ack_seen,
	output logic o_ready,
	output logic o_done,
	output logic o_nack,
	output rate_t o_rate,
	output logic o_bus_en,
	output bus_cmd_e o_cmd,
	output logic o_cmd_valid,
	output byte_t o_tx_byte,
	output logic o_ack_out,
	output logic o_txn_start
);

	seq_state_e state;
	seq_state_e nxt;
	// job settings held for the whole job
	logic rw_r;
	dev_addr_t dev_r;
	byte_t reg_r;
	byte_t wdata_r;
	// read bytes still to fetch
	rd_idx_t left;
	// sticky missing-ack flag for this job
	logic nack_r;
	// one command is on the bus
	logic cmd_busy;

	assign o_ready = (state == ST_IDLE);
	assign o_bus_en = (state != ST_IDLE);
	// ack every read byte but the last
	assign o_ack_out = (left != rd_idx_t'(1));

	// command and byte follow the state directly
	always_comb begin
		o_cmd = CMD_STOP;
		o_tx_byte = '0;
		case (state)
			ST_START1, ST_START2: o_cmd = CMD_START;
			ST_ADDR_W: begin
				o_cmd = CMD_WRITE;
				o_tx_byte = {dev_r, 1'b0};
			end
			ST_REG: begin
				o_cmd = CMD_WRITE;
				o_tx_byte = reg_r;
			end
			ST_DATA: begin
				o_cmd = CMD_WRITE;
				o_tx_byte = wdata_r;
			end
			ST_ADDR_R: begin
				o_cmd = CMD_WRITE;
				o_tx_byte = {dev_r, 1'b1};
			end
			ST_READ: o_cmd = CMD_READ;
			default: o_cmd = CMD_STOP;
		endcase
	end

	// where to go once the current command is done
	always_comb begin
		nxt = ST_IDLE;
		case (state)
			ST_START1: nxt = ST_ADDR_W;
			// address nack goes straight to stop
			ST_ADDR_W: nxt = i_ack_seen ? ST_REG : ST_STOP1;
			// reads stop after the register pointer
			ST_REG: nxt = (i_ack_seen && !rw_r) ? ST_DATA : ST_STOP1;
			ST_DATA: nxt = ST_STOP1;
			ST_STOP1: nxt = (rw_r && !nack_r) ? ST_START2 : ST_IDLE;
			ST_START2: nxt = ST_ADDR_R;
			ST_ADDR_R: nxt = i_ack_seen ? ST_READ : ST_STOP2;
			ST_READ: nxt = (left == rd_idx_t'(1)) ? ST_STOP2 : ST_READ;
			default: nxt = ST_IDLE;
		endcase
	end

	// host fields, only sampled on accept
	always_ff @(posedge i_clk) begin
		if (o_ready && i_start) begin
			dev_r <= i_dev_addr;
			reg_r <= i_reg_addr;
			wdata_r <= i_w_data;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ST_IDLE;
			rw_r <= 1'b0;
			left <= '0;
			nack_r <= 1'b0;
			cmd_busy <= 1'b0;
			o_rate <= RATE_DEFAULT;
			o_done <= 1'b0;
			o_nack <= 1'b0;
			o_cmd_valid <= 1'b0;
			o_txn_start <= 1'b0;
		end else begin
			o_done <= 1'b0;
			o_cmd_valid <= 1'b0;
			o_txn_start <= 1'b0;
			if (state == ST_IDLE) begin
				// start pulses outside idle are dropped
				if (i_start) begin
					state <= ST_START1;
					rw_r <= i_rw;
					o_rate <= i_clk_rate;
					left <= i_burst ? rd_idx_t'(BURST_LEN) : rd_idx_t'(1);
					nack_r <= 1'b0;
					o_cmd_valid <= 1'b1;
					o_txn_start <= i_rw;
				end
			end else if (cmd_busy && i_cmd_done) begin
				cmd_busy <= 1'b0;
				if (o_cmd == CMD_WRITE && !i_ack_seen)
					nack_r <= 1'b1;
				if (state == ST_READ)
					left <= left - rd_idx_t'(1);
				state <= nxt;
				if (nxt == ST_IDLE) begin
					o_done <= 1'b1;
					o_nack <= nack_r;
				end else begin
					o_cmd_valid <= 1'b1;
				end
			end else if (o_cmd_valid) begin
				cmd_busy <= 1'b1;
			end
		end
	end

	// engine takes one command at a time
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_cmd_valid |-> !cmd_busy);

	// host sees ready together with done
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_done |-> o_ready);

endmodule

`default_nettype wire

// File: source/i2c_byte_engine.sv
`default_nettype none

module i2c_byte_engine import i2c_pkg::*; (
	input wire logic i_clk,
	input wire logic i_rst_n,
	input wire logic i_tick,
	input wire bus_cmd_e i_cmd,
	input wire logic i_cmd_valid,
	input wire byte_t i_tx_byte,
	input wire logic i_ack_out,
	input wire logic i_sda,
	output logic o_scl,
	output logic o_sda_oe,
	output logic o_cmd_done,
	output logic o_ack_seen,
	output byte_t o_rx_byte,
	output logic o_rx_valid
);

	bus_cmd_e cmd_r;
	logic busy;
	// quarter inside the bit and bit inside the command
	logic [1:0] quarter;
	logic [3:0] bit_cnt;
	logic [3:0] last_bit;
	logic accept;
	logic step;
	logic last_tick;
	// transmit and receive shifters
	byte_t tx_sh;
	byte_t rx_sh;
	logic ack_r;
	// level to pull SDA during a data or ack bit
	logic sda_drive;

	assign accept = !busy && i_cmd_valid;
	assign step = busy && i_tick;
	// bytes are 8 data bits plus ack, start and stop a single bit
	assign last_bit = (cmd_r == CMD_WRITE || cmd_r == CMD_READ) ? 4'd8 : 4'd0;
	assign last_tick = step && quarter == 2'(QUARTERS_PER_BIT - 1) && bit_cnt == last_bit;
	assign o_rx_byte = rx_sh;

	always_comb begin
		if (bit_cnt == 4'd8)
			// master ack only on reads, slave owns the line on writes
			sda_drive = (cmd_r == CMD_READ) ? ack_r : 1'b0;
		else
			// zero bits pull, ones release
			sda_drive = (cmd_r == CMD_WRITE) ? ~tx_sh[7] : 1'b0;
	end

	// byte data loaded on accept
	always_ff @(posedge i_clk) begin
		if (accept) begin
			tx_sh <= i_tx_byte;
			ack_r <= i_ack_out;
		end else if (step && cmd_r == CMD_WRITE && quarter == 2'd3) begin
			tx_sh <= {tx_sh[6:0], 1'b0};
		end
		// read data sampled mid SCL high with MSB first
		if (step && cmd_r == CMD_READ && quarter == 2'd2 && bit_cnt != 4'd8)
			rx_sh <= {rx_sh[6:0], i_sda};
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy <= 1'b0;
			cmd_r <= CMD_STOP;
			quarter <= '0;
			bit_cnt <= '0;
			o_scl <= 1'b1;
			o_sda_oe <= 1'b0;
			o_cmd_done <= 1'b0;
			o_ack_seen <= 1'b0;
			o_rx_valid <= 1'b0;
		end else begin
			o_cmd_done <= 1'b0;
			o_rx_valid <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
				cmd_r <= i_cmd;
				quarter <= '0;
				bit_cnt <= '0;
			end else if (step) begin
				quarter <= quarter + 2'd1;
				if (quarter == 2'd3)
					bit_cnt <= bit_cnt + 4'd1;
				if (last_tick) begin
					busy <= 1'b0;
					o_cmd_done <= 1'b1;
					o_rx_valid <= (cmd_r == CMD_READ);
				end
				case (cmd_r)
					CMD_START: begin
						// SDA falls with SCL high, then SCL drops
						case (quarter)
							2'd0: o_scl <= 1'b1;
							2'd1: o_sda_oe <= 1'b1;
							2'd3: o_scl <= 1'b0;
							default: o_scl <= 1'b1;
						endcase
					end
					CMD_STOP: begin
						// SDA low under SCL low, SCL up, then SDA released
						case (quarter)
							2'd0: begin
								o_scl <= 1'b0;
								o_sda_oe <= 1'b1;
							end
							2'd1: o_scl <= 1'b1;
							2'd2: o_sda_oe <= 1'b0;
							default: o_scl <= 1'b1;
						endcase
					end
					default: begin
						// data bit sets SDA, holds SCL high for two quarters, then drops SCL
						case (quarter)
							2'd0: begin
								o_scl <= 1'b0;
								o_sda_oe <= sda_drive;
							end
							2'd1: o_scl <= 1'b1;
							2'd2: begin
								o_scl <= 1'b1;
								// slave ack is a low SDA in the ninth bit
								if (cmd_r == CMD_WRITE && bit_cnt == 4'd8)
									o_ack_seen <= ~i_sda;
							end
							default: o_scl <= 1'b0;
						endcase
					end
				endcase
			end
		end
	end

	// data and ack bits may only move SDA while SCL is low
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		($changed(o_sda_oe) && (cmd_r == CMD_WRITE || cmd_r == CMD_READ))
		|-> (!o_scl && !$past(o_scl)));

endmodule

`default_nettype wire

// File: source/i2c_read_buffer.sv
`default_nettype none

module i2c_read_buffer import i2c_pkg::*; (
	input wire logic i_clk,
	input wire logic i_rst_n,
	input wire logic i_clear,
	input wire logic i_wr_en,
	input wire byte_t i_wr_data,
	input wire rd_idx_t i_rd_idx,
	output byte_t o_rd_data
);

	byte_t mem [BURST_LEN];
	// next free slot
	rd_idx_t wr_ptr;
	logic wr_ok;

	// extra bytes past the burst are dropped
	assign wr_ok = i_wr_en && (wr_ptr < rd_idx_t'(BURST_LEN));
	// host read, out-of-range index reads zero
	assign o_rd_data = (i_rd_idx < rd_idx_t'(BURST_LEN)) ? mem[i_rd_idx] : '0;

	always_ff @(posedge i_clk) begin
		if (wr_ok)
			mem[wr_ptr] <= i_wr_data;
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			wr_ptr <= '0;
		else if (i_clear)
			wr_ptr <= '0;
		else if (wr_ok)
			wr_ptr <= wr_ptr + rd_idx_t'(1);
	end

	// sequencer never asks for more than a burst per job
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_wr_en |-> (wr_ptr < rd_idx_t'(BURST_LEN)));

endmodule

`default_nettype wire

// File: source/i2c_master_top.sv
`default_nettype none

module i2c_master_top import i2c_pkg::*; (
	input wire logic i_clk,
	input wire logic i_rst_n,
	// host job
	input wire logic i_start,
	input wire logic i_rw,
	input wire logic i_burst,
	input wire dev_addr_t i_dev_addr,
	input wire byte_t i_reg_addr,
	input wire byte_t i_w_data,
	input wire rate_t i_clk_rate,
	input wire rd_idx_t i_rd_idx,
	output logic o_ready,
	output logic o_done,
	output logic o_nack,
	output byte_t o_rd_data,
	// bus pins, SDA is open drain
	output logic o_scl,
	output logic o_sda_oe,
	input wire logic i_sda
);

	rate_t rate;
	logic bus_en;
	logic tick;
	bus_cmd_e cmd;
	logic cmd_valid;
	byte_t tx_byte;
	logic ack_out;
	logic cmd_done;
	logic ack_seen;
	byte_t rx_byte;
	logic rx_valid;
	logic txn_start;

	// quarter-bit ticks
	i2c_bit_timer u_timer (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_en(bus_en),
		.i_rate(rate),
		.o_tick(tick)
	);

	i2c_txn_sequencer u_seq (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_start(i_start),
		.i_rw(i_rw),
		.i_burst(i_burst),
		.i_dev_addr(i_dev_addr),
		.i_reg_addr(i_reg_addr),
		.i_w_data(i_w_data),
		.i_clk_rate(i_clk_rate),
		.i_cmd_done(cmd_done),
		.i_ack_seen(ack_seen),
		.o_ready(o_ready),
		.o_done(o_done),
		.o_nack(o_nack),
		.o_rate(rate),
		.o_bus_en(bus_en),
		.o_cmd(cmd),
		.o_cmd_valid(cmd_valid),
		.o_tx_byte(tx_byte),
		.o_ack_out(ack_out),
		.o_txn_start(txn_start)
	);

	i2c_byte_engine u_engine (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_tick(tick),
		.i_cmd(cmd),
		.i_cmd_valid(cmd_valid),
		.i_tx_byte(tx_byte),
		.i_ack_out(ack_out),
		.i_sda(i_sda),
		.o_scl(o_scl),
		.o_sda_oe(o_sda_oe),
		.o_cmd_done(cmd_done),
		.o_ack_seen(ack_seen),
		.o_rx_byte(rx_byte),
		.o_rx_valid(rx_valid)
	);

	// received bytes for the host
	i2c_read_buffer u_rdbuf (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_clear(txn_start),
		.i_wr_en(rx_valid),
		.i_wr_data(rx_byte),
		.i_rd_idx(i_rd_idx),
		.o_rd_data(o_rd_data)
	);

endmodule

`default_nettype wire

// File: test/i2c_slave_model.sv
`default_nettype none

module i2c_slave_model import i2c_pkg::*; #(
	parameter dev_addr_t slave_addr = 7'h48
) (
	input wire logic i_clk,
	input wire logic i_rst_n,
	input wire logic i_scl,
	input wire logic i_sda,
	output logic o_sda_pull,
	// ack state of the last byte sent to the master
	output logic o_last_ack
);

	byte_t regs [256];
	logic scl_q;
	logic sda_q;
	// a rise was seen since the last start, so a fall ends a bit
	logic seen_rise;
	logic [3:0] bitc;
	logic [7:0] byte_n;
	byte_t sh;
	byte_t tx;
	byte_t ptr;
	logic active;
	logic rw;
	logic sending;
	logic m_ack;

	always @(posedge i_clk) begin
		if (!i_rst_n) begin
			// register file preset from the seeded generator
			for (int i = 0; i < 256; i++)
				regs[i] <= byte_t'($urandom);
			scl_q <= 1'b1;
			sda_q <= 1'b1;
			seen_rise <= 1'b0;
			bitc <= '0;
			byte_n <= '0;
			ptr <= '0;
			active <= 1'b0;
			rw <= 1'b0;
			sending <= 1'b0;
			m_ack <= 1'b0;
			o_sda_pull <= 1'b0;
			o_last_ack <= 1'b1;
		end else begin
			scl_q <= i_scl;
			sda_q <= i_sda;
			if (i_scl && scl_q && sda_q && !i_sda) begin
				// start or repeated start
				seen_rise <= 1'b0;
				bitc <= '0;
				byte_n <= '0;
				active <= 1'b0;
				sending <= 1'b0;
				o_sda_pull <= 1'b0;
			end else if (i_scl && scl_q && !sda_q && i_sda) begin
				// stop
				seen_rise <= 1'b0;
				active <= 1'b0;
				sending <= 1'b0;
				o_sda_pull <= 1'b0;
			end else if (i_scl && !scl_q) begin
				seen_rise <= 1'b1;
				// ninth bit while sending carries the master ack
				if (bitc == 4'd8) begin
					if (sending) begin
						m_ack <= !i_sda;
						o_last_ack <= !i_sda;
					end
				end else begin
					sh <= {sh[6:0], i_sda};
				end
			end else if (!i_scl && scl_q && seen_rise) begin
				seen_rise <= 1'b0;
				if (bitc == 4'd8) begin
					bitc <= '0;
					byte_n <= byte_n + 8'd1;
					o_sda_pull <= 1'b0;
					sending <= 1'b0;
					// next read byte after address ack or master ack
					if (active && rw && (byte_n == 8'd0 || m_ack)) begin
						tx <= regs[ptr];
						o_sda_pull <= ~regs[ptr][7];
						ptr <= ptr + 8'd1;
						sending <= 1'b1;
					end
				end else begin
					bitc <= bitc + 4'd1;
					if (bitc == 4'd7) begin
						if (sending) begin
							// let the master drive its ack
							o_sda_pull <= 1'b0;
						end else if (byte_n == 8'd0) begin
							if (sh[7:1] == slave_addr) begin
								active <= 1'b1;
								rw <= sh[0];
								o_sda_pull <= 1'b1;
							end
						end else if (active) begin
							o_sda_pull <= 1'b1;
							// first byte is the pointer, then data with auto-increment
							if (byte_n == 8'd1) begin
								ptr <= sh;
							end else begin
								regs[ptr] <= sh;
								ptr <= ptr + 8'd1;
							end
						end
					end else if (sending) begin
						o_sda_pull <= ~tx[3'(6 - int'(bitc))];
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: test/tb_i2c_master.sv
`default_nettype none

module tb_i2c_master import i2c_pkg::*; ();

	localparam dev_addr_t slave_addr = 7'h48;
	localparam dev_addr_t wrong_addr = 7'h21;
	// one more write job of 29 bits at 32 clocks per bit, doubled
	localparam int drain_cycles = 2 * 29 * 32;
	// 18 jobs of at most 130 bits at 256 clocks per bit, plus slack and the drain window
	localparam int cycle_limit = 18 * 130 * 256 + 18 * 64 + drain_cycles + 2000;

	logic clk;
	logic rst_n;
	logic start;
	logic rw;
	logic burst;
	dev_addr_t dev_addr;
	byte_t reg_addr;
	byte_t w_data;
	rate_t clk_rate;
	rd_idx_t rd_idx;
	logic ready;
	logic done;
	logic nack;
	byte_t rd_data;
	logic scl;
	logic sda_oe;
	logic slave_pull;
	logic last_ack;
	wire logic sda;

	byte_t shadow [256];
	byte_t exp_bytes [BURST_LEN];
	logic exp_nack;
	logic exp_rw;
	int exp_len;
	int exp_high;
	int jobs_sent;
	int jobs_checked;
	int errors;
	int other_errors;
	int cycles;
	int scl_run;
	int scl_min;

	// open drain bus with pull-up
	assign sda = ~(sda_oe | slave_pull);

	i2c_master_top dut0 (
		.i_clk(clk), .i_rst_n(rst_n), .i_start(start), .i_rw(rw), .i_burst(burst),
		.i_dev_addr(dev_addr), .i_reg_addr(reg_addr), .i_w_data(w_data),
		.i_clk_rate(clk_rate), .i_rd_idx(rd_idx), .o_ready(ready), .o_done(done),
		.o_nack(nack), .o_rd_data(rd_data), .o_scl(scl), .o_sda_oe(sda_oe), .i_sda(sda)
	);

	i2c_slave_model #(.slave_addr(slave_addr)) slave0 (
		.i_clk(clk), .i_rst_n(rst_n), .i_scl(scl), .i_sda(sda),
		.o_sda_pull(slave_pull), .o_last_ack(last_ack)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// expected bytes and nack from the shadow with writes applied to it
	function automatic logic predict_job(input logic rw_f, input logic burst_f,
			input dev_addr_t dev_f, input byte_t reg_f, input byte_t data_f);
		logic miss;
		int k;
		miss = (dev_f != slave_addr);
		for (k = 0; k < BURST_LEN; k++)
			exp_bytes[k] = '0;
		if (!miss && rw_f) begin
			for (k = 0; k < (burst_f ? BURST_LEN : 1); k++)
				exp_bytes[k] = shadow[8'(int'(reg_f) + k)];
		end else if (!miss) begin
			shadow[reg_f] = data_f;
		end
		return miss;
	endfunction

	// scl high time of a data bit is half of 2^(code+1) and bad codes run as 6
	function automatic int scl_high_clks(input rate_t code);
		return 1 << ((code >= 3'd4 && code <= 3'd7) ? int'(code) : 6);
	endfunction

	task automatic launch_job(input logic rw_j, input logic burst_j, input dev_addr_t dev_j,
			input byte_t reg_j, input byte_t data_j, input rate_t rate_j, input logic poke);
		while (!ready || jobs_checked < jobs_sent)
			@(posedge clk);
		exp_nack = predict_job(rw_j, burst_j, dev_j, reg_j, data_j);
		exp_rw = rw_j;
		exp_len = burst_j ? BURST_LEN : 1;
		exp_high = scl_high_clks(rate_j);
		rw <= rw_j;
		burst <= burst_j;
		dev_addr <= dev_j;
		reg_addr <= reg_j;
		w_data <= data_j;
		clk_rate <= rate_j;
		start <= 1'b1;
		jobs_sent++;
		@(posedge clk);
		start <= 1'b0;
		// extra start pulses early in the busy job and far from its end
		if (poke) begin
			repeat (10) begin
				@(posedge clk);
				start <= !ready;
				@(posedge clk);
				start <= 1'b0;
			end
		end
	endtask

	// shortest scl high run in the current job
	always @(posedge clk) begin
		if (start && ready) begin
			scl_run <= 0;
			scl_min <= 1 << 20;
		end else if (scl) begin
			scl_run <= scl_run + 1;
		end else if (scl_run > 0) begin
			if (scl_run < scl_min)
				scl_min <= scl_run;
			scl_run <= 0;
		end
	end

	// compare at each done
	initial begin
		int k;
		forever begin
			@(posedge clk);
			if (done) begin
				if (nack !== exp_nack) begin
					$display("Fail %0t: nack %b, expected %b", $time, nack, exp_nack);
					errors++;
				end
				if (!ready) begin
					$display("Fail %0t: ready low at done", $time);
					errors++;
				end
				if (scl_min != exp_high) begin
					$display("Fail %0t: scl high %0d clocks, expected %0d", $time,
						scl_min, exp_high);
					errors++;
				end
				for (k = 0; k < 256; k++) begin
					if (slave0.regs[k] !== shadow[k]) begin
						$display("Fail %0t: reg %0d is %h, expected %h", $time, k,
							slave0.regs[k], shadow[k]);
						errors++;
					end
				end
				if (exp_rw && !exp_nack) begin
					// last byte must be nacked by the master
					if (last_ack !== 1'b0) begin
						$display("Fail %0t: last read byte was acked", $time);
						errors++;
					end
					for (k = 0; k < exp_len; k++) begin
						rd_idx <= rd_idx_t'(k);
						@(posedge clk);
						if (rd_data !== exp_bytes[k]) begin
							$display("Fail %0t: byte %0d is %h, expected %h", $time, k,
								rd_data, exp_bytes[k]);
							errors++;
						end
					end
				end
				jobs_checked++;
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles <= cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: jobs did not finish within %0d cycles", cycle_limit);
		$display("errors: %0d wrong values, %0d other", errors, other_errors + 1);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		int k;
		rate_t codes [5];
		void'($urandom(32'h8fdd));
		codes = '{3'd4, 3'd5, 3'd6, 3'd7, 3'd2};
		errors = 0;
		other_errors = 0;
		jobs_sent = 0;
		jobs_checked = 0;
		rst_n = 1'b0;
		start = 1'b0;
		rw = 1'b0;
		burst = 1'b0;
		dev_addr = '0;
		reg_addr = '0;
		w_data = '0;
		clk_rate = 3'd4;
		rd_idx = '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		for (k = 0; k < 256; k++)
			shadow[k] = slave0.regs[k];
		// writes and then reads of random registers
		repeat (4)
			launch_job(1'b0, 1'b0, slave_addr, byte_t'($urandom), byte_t'($urandom), 3'd5, 1'b0);
		repeat (4)
			launch_job(1'b1, 1'b0, slave_addr, byte_t'($urandom), 8'h00, 3'd4, 1'b0);
		launch_job(1'b1, 1'b1, slave_addr, byte_t'($urandom), 8'h00, 3'd7, 1'b0);
		// burst across the top of the register file
		launch_job(1'b1, 1'b1, slave_addr, 8'hfa, 8'h00, 3'd7, 1'b0);
		launch_job(1'b0, 1'b0, wrong_addr, 8'h10, 8'h5a, 3'd4, 1'b0);
		launch_job(1'b1, 1'b0, wrong_addr, 8'h10, 8'h00, 3'd4, 1'b0);
		for (k = 0; k < 5; k++)
			launch_job(1'b1, 1'b0, slave_addr, byte_t'($urandom), 8'h00, codes[k], 1'b0);
		launch_job(1'b0, 1'b0, slave_addr, 8'h33, byte_t'($urandom), 3'd4, 1'b1);
		while (jobs_checked < jobs_sent)
			@(posedge clk);
		// a job started by a dropped pulse would end inside this window
		repeat (drain_cycles) @(posedge clk);
		if (jobs_checked != jobs_sent) begin
			$display("extra job ran: %0d done pulses for %0d starts", jobs_checked, jobs_sent);
			other_errors++;
		end
		$display("errors: %0d wrong values, %0d other", errors, other_errors);
		if (errors == 0 && other_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
source/i2c_pkg.sv
source/i2c_bit_timer.sv
source/i2c_txn_sequencer.sv
source/i2c_byte_engine.sv
source/i2c_read_buffer.sv
source/i2c_master_top.sv
test/i2c_slave_model.sv
test/tb_i2c_master.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the I2C master testbench with Verilator
set -e
cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f --top-module tb_i2c_master \
	-Mdir build/obj_dir -o tb_i2c_master

./build/obj_dir/tb_i2c_master | tee build/sim.log

if grep -q "Simulation FAILED" build/sim.log; then
	exit 1
fi
grep -q "Simulation PASSED" build/sim.log
